//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f tb.f --top-module tb_core -Mdir obj_dir
	./obj_dir/Vtb_core

clean:
	rm -rf obj_dir

//--- bench/tb_core.sv
`timescale 1ns/1ns
`include "core_config.svh"

module tb_core
    import core_pkg::*, rv_isa_pkg::*;
();

    localparam int NUM_INSTS   = 2000;
    localparam int MAX_EDGES   = 16384;
    localparam int DRAIN_LIMIT = 20;

    logic      clk;
    logic      reset_i;
    logic      inst_valid_i;
    word_t     inst_i;
    word_t     pc_i;
    logic      wb_we_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;
    logic      redirect_o;
    word_t     redirect_pc_o;

    // expected events, indexed by the edge after which they are visible
    logic      exp_we    [MAX_EDGES];
    reg_addr_t exp_waddr [MAX_EDGES];
    word_t     exp_wdata [MAX_EDGES];
    logic      exp_redir [MAX_EDGES];
    word_t     exp_rpc   [MAX_EDGES];

    // architectural registers of the model
    word_t arch [32];

    int edge_cnt;
    int last_event_edge;
    int last_redir_edge;
    int n_writes;
    int n_redirs;
    int n_squashed;

    core_top uut (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .wb_we_o       (wb_we_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_write(input string name, input reg_addr_t exp_addr,
                               input reg_addr_t act_addr, input word_t exp_data,
                               input word_t act_data);
        if (act_addr !== exp_addr || act_data !== exp_data) begin
            $display("ERROR %s: expected x%0d = %h, actual x%0d = %h",
                     name, exp_addr, exp_data, act_addr, act_data);
            stop_run();
        end
    endtask

    task automatic check_redirect(input string name, input word_t exp_pc, input word_t act_pc);
        if (act_pc !== exp_pc) begin
            $display("ERROR %s: expected %h, actual %h", name, exp_pc, act_pc);
            stop_run();
        end
    endtask

    task automatic check_cycle();
        if (wb_we_o !== exp_we[edge_cnt]) begin
            if (wb_we_o === 1'b1) begin
                $display("unexpected writeback to x%0d after edge %0d", wb_addr_o, edge_cnt);
            end else begin
                $display("missing writeback after edge %0d", edge_cnt);
            end
            stop_run();
        end
        if (wb_we_o === 1'b1) begin
            if (wb_addr_o == `NOP_REG_ADDR) begin
                $display("writeback names x0 after edge %0d", edge_cnt);
                stop_run();
            end
            check_write($sformatf("writeback edge %0d", edge_cnt), exp_waddr[edge_cnt],
                        wb_addr_o, exp_wdata[edge_cnt], wb_data_o);
        end
        if (redirect_o !== exp_redir[edge_cnt]) begin
            if (redirect_o === 1'b1) begin
                $display("unexpected redirect to %h after edge %0d", redirect_pc_o, edge_cnt);
            end else begin
                $display("missing redirect after edge %0d", edge_cnt);
            end
            stop_run();
        end
        if (redirect_o === 1'b1) begin
            check_redirect($sformatf("redirect edge %0d", edge_cnt), exp_rpc[edge_cnt],
                           redirect_pc_o);
        end
    endtask

    // drive after a falling edge, check at the next falling edge
    task automatic run_cycle(input logic valid, input word_t inst, input word_t pc);
        inst_valid_i = valid;
        inst_i       = inst;
        pc_i         = pc;
        @(posedge clk);
        edge_cnt++;
        @(negedge clk);
        check_cycle();
    endtask

    function automatic reg_addr_t pick_reg();
        return reg_addr_t'($urandom_range(7, 0));
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t sext13(input logic [12:0] v);
        return {{19{v[12]}}, v};
    endfunction

    function automatic word_t sext21(input logic [20:0] v);
        return {{11{v[20]}}, v};
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // random instruction plus its architectural effect
    task automatic gen_inst(input word_t pc, output word_t inst, output logic wr,
                            output reg_addr_t rd, output word_t wdata,
                            output logic redir, output word_t tgt);
        int          kind;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [12:0] imm13;
        logic [19:0] imm20;
        logic [20:0] imm21;
        logic        alt;
        kind  = int'($urandom_range(99, 0));
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        f3    = 3'($urandom_range(7, 0));
        imm12 = 12'($urandom);
        imm13 = {12'($urandom), 1'b0};
        imm20 = 20'($urandom);
        imm21 = {20'($urandom), 1'b0};
        alt   = 1'($urandom_range(1, 0));
        wr    = 1'b0;
        wdata = '0;
        redir = 1'b0;
        tgt   = '0;
        if (kind < 8) begin
            inst  = {imm20, rd, OPC_LUI};
            wr    = 1'b1;
            wdata = {imm20, 12'h000};
        end else if (kind < 14) begin
            inst  = {imm20, rd, OPC_AUIPC};
            wr    = 1'b1;
            wdata = pc + {imm20, 12'h000};
        end else if (kind < 20) begin
            inst  = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, OPC_JAL};
            wr    = 1'b1;
            wdata = pc + 32'd4;
            redir = 1'b1;
            tgt   = pc + sext21(imm21);
        end else if (kind < 26) begin
            inst  = {imm12, rs1, 3'b000, rd, OPC_JALR};
            wr    = 1'b1;
            wdata = pc + 32'd4;
            redir = 1'b1;
            tgt   = (arch[rs1] + sext12(imm12)) & 32'hffff_fffe;
        end else if (kind < 44) begin
            // 010 and 011 are not branch conditions
            if (f3[2:1] == 2'b01) begin
                f3 = f3 ^ 3'b110;
            end
            inst  = {imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11], OPC_BRANCH};
            redir = branch_ref(f3, arch[rs1], arch[rs2]);
            tgt   = redir ? pc + sext13(imm13) : '0;
        end else if (kind < 70) begin
            if (f3 == 3'b001) begin
                imm12 = {7'b0000000, imm12[4:0]};
            end else if (f3 == 3'b101) begin
                imm12 = {1'b0, alt, 5'b00000, imm12[4:0]};
            end
            inst  = {imm12, rs1, f3, rd, OPC_OP_IMM};
            wr    = 1'b1;
            wdata = alu_ref(f3, alt && (f3 == 3'b101), arch[rs1], sext12(imm12));
        end else if (kind < 94) begin
            alt   = alt && (f3 == 3'b000 || f3 == 3'b101);
            inst  = {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, OPC_OP};
            wr    = 1'b1;
            wdata = alu_ref(f3, alt, arch[rs1], arch[rs2]);
        end else if (kind < 97) begin
            if (alt) begin
                inst = {imm12, rs1, 3'b010, rd, OPC_LOAD};
            end else begin
                inst = {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], OPC_STORE};
            end
        end else if (kind == 97) begin
            inst = {imm12, rs1, f3 | 3'b001, rd, OPC_JALR};
        end else if (kind == 98) begin
            inst = {imm13[12], imm13[10:5], rs2, rs1, 2'b01, alt, imm13[4:1], imm13[11],
                    OPC_BRANCH};
        end else begin
            inst = {imm12, rs1, f3, rd, 7'b1110011};
        end
        if (rd == `NOP_REG_ADDR) begin
            wr = 1'b0;
        end
    endtask

    initial begin
        word_t     pc;
        word_t     inst;
        logic      wr;
        reg_addr_t rd;
        word_t     wdata;
        logic      redir;
        word_t     tgt;
        int        gap;
        int        accept;
        int        waited;
        void'($urandom(32'hfa523dd2));
        reset_i      = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        edge_cnt        = 0;
        last_event_edge = 0;
        last_redir_edge = -10;
        n_writes   = 0;
        n_redirs   = 0;
        n_squashed = 0;
        for (int i = 0; i < MAX_EDGES; i++) begin
            exp_we[i]    = 1'b0;
            exp_waddr[i] = '0;
            exp_wdata[i] = '0;
            exp_redir[i] = 1'b0;
            exp_rpc[i]   = '0;
        end
        for (int i = 0; i < 32; i++) begin
            arch[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        // quiet pipeline after reset
        repeat (10) run_cycle(1'b0, '0, '0);

        pc = 32'h0000_1000;
        for (int n = 0; n < NUM_INSTS; n++) begin
            gap = int'($urandom_range(2, 0));
            for (int g = 0; g < gap; g++) begin
                run_cycle(1'b0, '0, '0);
            end
            accept = edge_cnt + 1;
            gen_inst(pc, inst, wr, rd, wdata, redir, tgt);
            if (last_redir_edge == accept - 1) begin
                n_squashed++;
            end else begin
                if (wr) begin
                    arch[rd]              = wdata;
                    exp_we[accept + 2]    = 1'b1;
                    exp_waddr[accept + 2] = rd;
                    exp_wdata[accept + 2] = wdata;
                    last_event_edge       = accept + 2;
                    n_writes++;
                end
                if (redir) begin
                    exp_redir[accept + 1] = 1'b1;
                    exp_rpc[accept + 1]   = tgt;
                    last_redir_edge       = accept;
                    if (last_event_edge < accept + 1) begin
                        last_event_edge = accept + 1;
                    end
                    n_redirs++;
                end
            end
            run_cycle(1'b1, inst, pc);
            pc = pc + 32'd4;
        end

        waited = 0;
        while (edge_cnt < last_event_edge) begin
            if (waited >= DRAIN_LIMIT) begin
                $display("pipeline did not drain within %0d cycles", DRAIN_LIMIT);
                stop_run();
            end
            run_cycle(1'b0, '0, '0);
            waited++;
        end
        repeat (3) run_cycle(1'b0, '0, '0);

        $display("%0d writes, %0d redirects, %0d squashed", n_writes, n_redirs, n_squashed);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/pipe_ctrl.sv
verilog/id.sv
verilog/regfile.sv
verilog/ex.sv
verilog/core_top.sv
bench/tb_core.sv

//--- verilog/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath word width
`define XLEN 32

// register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// x0, also the destination of anything that writes nothing
`define NOP_REG_ADDR 5'd0

`endif

//--- verilog/core_pkg.sv
`include "core_config.svh"

package core_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // what ex does with the micro-op
    typedef enum logic [2:0] {
        AOP_NOP    = 3'd0,
        AOP_LUI    = 3'd1,
        AOP_AUIPC  = 3'd2,
        AOP_JAL    = 3'd3,
        AOP_JALR   = 3'd4,
        AOP_BRANCH = 3'd5,
        AOP_ALU    = 3'd6
    } alu_op_e;

    // alu function or branch condition
    typedef enum logic [4:0] {
        SEL_ADD  = 5'd0,
        SEL_SUB  = 5'd1,
        SEL_SLL  = 5'd2,
        SEL_SLT  = 5'd3,
        SEL_SLTU = 5'd4,
        SEL_XOR  = 5'd5,
        SEL_SRL  = 5'd6,
        SEL_SRA  = 5'd7,
        SEL_OR   = 5'd8,
        SEL_AND  = 5'd9,
        SEL_BEQ  = 5'd16,
        SEL_BNE  = 5'd17,
        SEL_BLT  = 5'd18,
        SEL_BGE  = 5'd19,
        SEL_BLTU = 5'd20,
        SEL_BGEU = 5'd21
    } alu_sel_e;

endpackage

//--- verilog/core_top.sv
`timescale 1ns/1ns

module core_top
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      inst_valid_i,
    input  word_t     inst_i,
    input  word_t     pc_i,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o,
    output logic      redirect_o,
    output word_t     redirect_pc_o
);

    word_t     id_inst;
    word_t     id_pc;
    logic      id_valid;
    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    word_t     reg1_data;
    word_t     reg2_data;
    word_t     dec_pc;
    alu_op_e   aluop;
    alu_sel_e  alusel;
    word_t     imm;
    word_t     reg1;
    word_t     reg2;
    logic      wreg;
    reg_addr_t wd;
    logic      ex_wreg;
    reg_addr_t ex_wd;
    word_t     ex_wdata;

    pipe_ctrl u_ctrl (
        .clk          (clk),
        .reset_i      (reset_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .redirect_i   (redirect_o),
        .id_inst_o    (id_inst),
        .id_pc_o      (id_pc),
        .id_valid_o   (id_valid),
        .ex_valid_o   ()
    );

    id u_id (
        .pc_i        (id_pc),
        .inst_i      (id_inst),
        .ex_wreg_i   (ex_wreg),
        .ex_wdata_i  (ex_wdata),
        .ex_wd_i     (ex_wd),
        .mem_wreg_i  (wb_we_o),
        .mem_wdata_i (wb_data_o),
        .mem_wd_i    (wb_addr_o),
        .reg1_data_i (reg1_data),
        .reg2_data_i (reg2_data),
        .reg1_read_o (reg1_read),
        .reg2_read_o (reg2_read),
        .reg1_addr_o (reg1_addr),
        .reg2_addr_o (reg2_addr),
        .id_pc_o     (dec_pc),
        .aluop_o     (aluop),
        .alusel_o    (alusel),
        .imm_o       (imm),
        .reg1_o      (reg1),
        .reg2_o      (reg2),
        .wreg_o      (wreg),
        .wd_o        (wd)
    );

    regfile u_rf (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (wb_we_o),
        .waddr_i  (wb_addr_o),
        .wdata_i  (wb_data_o),
        .re1_i    (reg1_read),
        .raddr1_i (reg1_addr),
        .re2_i    (reg2_read),
        .raddr2_i (reg2_addr),
        .rdata1_o (reg1_data),
        .rdata2_o (reg2_data)
    );

    ex u_ex (
        .clk           (clk),
        .reset_i       (reset_i),
        .valid_i       (id_valid),
        .pc_i          (dec_pc),
        .aluop_i       (aluop),
        .alusel_i      (alusel),
        .imm_i         (imm),
        .reg1_i        (reg1),
        .reg2_i        (reg2),
        .wreg_i        (wreg),
        .wd_i          (wd),
        .ex_wreg_o     (ex_wreg),
        .ex_wd_o       (ex_wd),
        .ex_wdata_o    (ex_wdata),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .wb_wreg_o     (wb_we_o),
        .wb_wd_o       (wb_addr_o),
        .wb_wdata_o    (wb_data_o)
    );

endmodule

//--- verilog/ex.sv
`timescale 1ns/1ns

module ex
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      valid_i,
    input  word_t     pc_i,
    input  alu_op_e   aluop_i,
    input  alu_sel_e  alusel_i,
    input  word_t     imm_i,
    input  word_t     reg1_i,
    input  word_t     reg2_i,
    input  logic      wreg_i,
    input  reg_addr_t wd_i,
    output logic      ex_wreg_o,
    output reg_addr_t ex_wd_o,
    output word_t     ex_wdata_o,
    output logic      redirect_o,
    output word_t     redirect_pc_o,
    output logic      wb_wreg_o,
    output reg_addr_t wb_wd_o,
    output word_t     wb_wdata_o
);

    logic      valid_q;
    alu_op_e   aluop_q;
    alu_sel_e  alusel_q;
    word_t     pc_q;
    word_t     imm_q;
    word_t     reg1_q;
    word_t     reg2_q;
    logic      wreg_q;
    reg_addr_t wd_q;
    word_t     op2;
    word_t     alu_out;
    word_t     result;
    logic      taken;
    word_t     target;

    // id/ex, an empty slot carries a nop
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            aluop_q <= AOP_NOP;
        end else begin
            valid_q <= valid_i;
            aluop_q <= valid_i ? aluop_i : AOP_NOP;
        end
    end

    always_ff @(posedge clk) begin
        alusel_q <= alusel_i;
        pc_q     <= pc_i;
        imm_q    <= imm_i;
        reg1_q   <= reg1_i;
        reg2_q   <= reg2_i;
        wreg_q   <= wreg_i;
        wd_q     <= wd_i;
    end

    // decoder zeroes whichever of reg2 and imm is unused
    assign op2 = reg2_q | imm_q;

    always_comb begin
        case (alusel_q)
            SEL_ADD:  alu_out = reg1_q + op2;
            SEL_SUB:  alu_out = reg1_q - op2;
            SEL_SLL:  alu_out = reg1_q << op2[4:0];
            SEL_SLT:  alu_out = word_t'($signed(reg1_q) < $signed(op2));
            SEL_SLTU: alu_out = word_t'(reg1_q < op2);
            SEL_XOR:  alu_out = reg1_q ^ op2;
            SEL_SRL:  alu_out = reg1_q >> op2[4:0];
            SEL_SRA:  alu_out = word_t'($signed(reg1_q) >>> op2[4:0]);
            SEL_OR:   alu_out = reg1_q | op2;
            SEL_AND:  alu_out = reg1_q & op2;
            default:  alu_out = '0;
        endcase
    end

    always_comb begin
        case (aluop_q)
            AOP_LUI:           result = imm_q;
            AOP_AUIPC:         result = pc_q + imm_q;
            AOP_JAL, AOP_JALR: result = pc_q + word_t'(4);
            AOP_ALU:           result = alu_out;
            default:           result = '0;
        endcase
    end

    always_comb begin
        taken  = 1'b0;
        target = pc_q + imm_q;
        case (aluop_q)
            AOP_JAL: taken = 1'b1;
            AOP_JALR: begin
                taken  = 1'b1;
                target = (reg1_q + imm_q) & ~word_t'(1);
            end
            AOP_BRANCH: begin
                case (alusel_q)
                    SEL_BEQ:  taken = (reg1_q == reg2_q);
                    SEL_BNE:  taken = (reg1_q != reg2_q);
                    SEL_BLT:  taken = ($signed(reg1_q) < $signed(reg2_q));
                    SEL_BGE:  taken = ($signed(reg1_q) >= $signed(reg2_q));
                    SEL_BLTU: taken = (reg1_q < reg2_q);
                    SEL_BGEU: taken = (reg1_q >= reg2_q);
                    default:  taken = 1'b0;
                endcase
            end
            default: begin
            end
        endcase
    end

    assign redirect_o    = taken;
    assign redirect_pc_o = target;

    assign ex_wreg_o  = valid_q && wreg_q;
    assign ex_wd_o    = wd_q;
    assign ex_wdata_o = result;

    // ex/wb
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_wreg_o <= 1'b0;
        end else begin
            wb_wreg_o <= ex_wreg_o;
        end
    end

    always_ff @(posedge clk) begin
        wb_wd_o    <= wd_q;
        wb_wdata_o <= result;
    end

    redirect_needs_valid: assert property (
        @(posedge clk) disable iff (reset_i)
        redirect_o |-> valid_q
    );

endmodule

//--- verilog/id.sv
`timescale 1ns/1ns
`include "core_config.svh"

module id
    import core_pkg::*, rv_isa_pkg::*;
(
    input  word_t     pc_i,
    input  word_t     inst_i,

    // forwarding from ex
    input  logic      ex_wreg_i,
    input  word_t     ex_wdata_i,
    input  reg_addr_t ex_wd_i,

    // forwarding from the wb stage
    input  logic      mem_wreg_i,
    input  word_t     mem_wdata_i,
    input  reg_addr_t mem_wd_i,

    input  word_t     reg1_data_i,
    input  word_t     reg2_data_i,

    output logic      reg1_read_o,
    output logic      reg2_read_o,
    output reg_addr_t reg1_addr_o,
    output reg_addr_t reg2_addr_o,

    output word_t     id_pc_o,
    output alu_op_e   aluop_o,
    output alu_sel_e  alusel_o,
    output word_t     imm_o,
    output word_t     reg1_o,
    output word_t     reg2_o,
    output logic      wreg_o,
    output reg_addr_t wd_o
);

    opcode_e    opcode;
    branch_f3_e br_f3;
    alu_f3_e    alu_f3;
    reg_addr_t  rd;
    logic       alt_f7;
    logic       rd_write;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign br_f3  = branch_f3_e'(inst_i[14:12]);
    assign alu_f3 = alu_f3_e'(inst_i[14:12]);
    assign rd     = inst_i[11:7];
    assign alt_f7 = inst_i[30];

    assign imm_i = {{21{inst_i[31]}}, inst_i[30:20]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    assign id_pc_o = pc_i;

    always_comb begin
        aluop_o     = AOP_NOP;
        alusel_o    = SEL_ADD;
        imm_o       = '0;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        reg1_addr_o = inst_i[19:15];
        reg2_addr_o = inst_i[24:20];
        rd_write    = 1'b0;
        case (opcode)
            OPC_LUI: begin
                aluop_o  = AOP_LUI;
                imm_o    = imm_u;
                rd_write = 1'b1;
            end
            OPC_AUIPC: begin
                aluop_o  = AOP_AUIPC;
                imm_o    = imm_u;
                rd_write = 1'b1;
            end
            OPC_JAL: begin
                aluop_o  = AOP_JAL;
                imm_o    = imm_j;
                rd_write = 1'b1;
            end
            OPC_JALR: begin
                if (inst_i[14:12] == 3'b000) begin
                    aluop_o     = AOP_JALR;
                    imm_o       = imm_i;
                    reg1_read_o = 1'b1;
                    rd_write    = 1'b1;
                end
            end
            OPC_BRANCH: begin
                // 010 and 011 are not branches, left as a no-op
                if (inst_i[14:13] != 2'b01) begin
                    aluop_o     = AOP_BRANCH;
                    imm_o       = imm_b;
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                    case (br_f3)
                        F3_BEQ:  alusel_o = SEL_BEQ;
                        F3_BNE:  alusel_o = SEL_BNE;
                        F3_BLT:  alusel_o = SEL_BLT;
                        F3_BGE:  alusel_o = SEL_BGE;
                        F3_BLTU: alusel_o = SEL_BLTU;
                        default: alusel_o = SEL_BGEU;
                    endcase
                end
            end
            OPC_OP_IMM, OPC_OP: begin
                aluop_o     = AOP_ALU;
                reg1_read_o = 1'b1;
                rd_write    = 1'b1;
                if (opcode == OPC_OP) begin
                    reg2_read_o = 1'b1;
                end else begin
                    imm_o = imm_i;
                end
                case (alu_f3)
                    // addi has no sub form
                    F3_ADD:  alusel_o = (alt_f7 && opcode == OPC_OP) ? SEL_SUB : SEL_ADD;
                    F3_SLL:  alusel_o = SEL_SLL;
                    F3_SLT:  alusel_o = SEL_SLT;
                    F3_SLTU: alusel_o = SEL_SLTU;
                    F3_XOR:  alusel_o = SEL_XOR;
                    F3_SR:   alusel_o = alt_f7 ? SEL_SRA : SEL_SRL;
                    F3_OR:   alusel_o = SEL_OR;
                    default: alusel_o = SEL_AND;
                endcase
            end
            default: begin
            end
        endcase

        wreg_o = rd_write && (rd != `NOP_REG_ADDR);
        wd_o   = wreg_o ? rd : `NOP_REG_ADDR;
    end

    // ex beats wb beats the register file
    function automatic word_t fwd_operand(
        input logic      re,
        input reg_addr_t addr,
        input word_t     rf_data
    );
        word_t val;
        if (!re) begin
            val = '0;
        end else if (ex_wreg_i && (ex_wd_i == addr)) begin
            val = ex_wdata_i;
        end else if (mem_wreg_i && (mem_wd_i == addr)) begin
            val = mem_wdata_i;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign reg1_o = fwd_operand(reg1_read_o, reg1_addr_o, reg1_data_i);
    assign reg2_o = fwd_operand(reg2_read_o, reg2_addr_o, reg2_data_i);

endmodule

//--- verilog/pipe_ctrl.sv
`timescale 1ns/1ns

module pipe_ctrl
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  inst_valid_i,
    input  word_t inst_i,
    input  word_t pc_i,
    input  logic  redirect_i,
    output word_t id_inst_o,
    output word_t id_pc_o,
    output logic  id_valid_o,
    output logic  ex_valid_o
);

    word_t inst_q;
    word_t pc_q;
    logic  id_valid_q;
    logic  ex_valid_q;

    // decode latch, loaded on the strobe only
    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            inst_q <= inst_i;
            pc_q   <= pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_valid_q <= 1'b0;
            ex_valid_q <= 1'b0;
        end else begin
            id_valid_q <= inst_valid_i;
            ex_valid_q <= id_valid_o;
        end
    end

    // a redirect in ex kills the instruction behind it
    assign id_valid_o = id_valid_q && !redirect_i;

    assign id_inst_o  = inst_q;
    assign id_pc_o    = pc_q;
    assign ex_valid_o = ex_valid_q;

    squash_empties_ex: assert property (
        @(posedge clk) disable iff (reset_i)
        redirect_i |=> !ex_valid_o
    );

endmodule

//--- verilog/regfile.sv
`timescale 1ns/1ns
`include "core_config.svh"

module regfile
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  logic      re1_i,
    input  reg_addr_t raddr1_i,
    input  logic      re2_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != `NOP_REG_ADDR)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // no bypass here, the decoder forwards from wb
    assign rdata1_o = (re1_i && (raddr1_i != `NOP_REG_ADDR)) ? regs[raddr1_i] : '0;
    assign rdata2_o = (re2_i && (raddr2_i != `NOP_REG_ADDR)) ? regs[raddr2_i] : '0;

    // decoder already drops x0 destinations
    no_x0_write: assert property (
        @(posedge clk) disable iff (reset_i)
        we_i |-> (waddr_i != `NOP_REG_ADDR)
    );

endmodule

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // funct3 of conditional branches
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

    // funct3 of OP and OP-IMM, funct7 picks sub and sra
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_e;

endpackage
